// File: include/ray_consts.svh
`ifndef RAY_CONSTS_SVH
`define RAY_CONSTS_SVH

// screen size in pixels, kept small so a frame simulates quickly
`define SCREEN_WIDTH  16
`define SCREEN_HEIGHT 12

// signed 8.24 fixed point
`define FP_FRAC_BITS  24
`define FP_ONE        (32'sd1 <<< `FP_FRAC_BITS)

// 2/width and 2/height in 8.24, truncated
`define INV_HALF_WIDTH  (32'((64'sd2 <<< `FP_FRAC_BITS) / `SCREEN_WIDTH))
`define INV_HALF_HEIGHT (32'((64'sd2 <<< `FP_FRAC_BITS) / `SCREEN_HEIGHT))

// width/height in 8.24
`define ASPECT_RATIO    (32'(((64'sd1 * `SCREEN_WIDTH) <<< `FP_FRAC_BITS) / `SCREEN_HEIGHT))

// cycles from input strobe to output strobe
`define INV_SQRT_LATENCY 5
// ndc, scale, vector, inverse square root, normalize
`define RAY_GEN_LATENCY  9

`endif

// File: rtl/fixed_point_pkg.sv
`include "ray_consts.svh"

package fixed_point_pkg;

    // signed 8.24 scalar
    typedef logic signed [31:0] fp;

    // three-component vector, x in the top word
    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // full-width product, then drop the fraction bits
    // the arithmetic shift rounds toward negative infinity
    function automatic fp fp_mul(
        input fp a,
        input fp b
    );
        logic signed [63:0] product;
        product = 64'(a) * 64'(b);
        return fp'(product >>> `FP_FRAC_BITS);
    endfunction

    // each product is truncated before the sum
    function automatic fp vec3_dot(
        input vec3 a,
        input vec3 b
    );
        fp sum_xy;
        sum_xy = fp_mul(a.x, b.x) + fp_mul(a.y, b.y);
        return sum_xy + fp_mul(a.z, b.z);
    endfunction

endpackage

// File: rtl/ray_pkg.sv
package ray_pkg;

    // screen position of one pixel
    // x counts fastest, origin at the top left
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        // final pixel of the frame
        logic       last;
    } pixel_coord_t;

    // unit direction in camera space, tagged with its pixel
    // z is always negative since the camera looks along -z
    typedef struct packed {
        fixed_point_pkg::vec3 direction;
        pixel_coord_t         pixel;
    } ray_t;

endpackage

// File: rtl/pixel_scanner.sv
`timescale 1ns/100ps
`include "ray_consts.svh"

module pixel_scanner (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_start,
    output ray_pkg::pixel_coord_t pixel,
    output logic                  pixel_valid,
    output logic                  busy
);

    logic [9:0] x_cnt;
    logic [9:0] y_cnt;
    logic       end_of_row;
    logic       end_of_frame;

    assign end_of_row   = (x_cnt == 10'(`SCREEN_WIDTH - 1));
    assign end_of_frame = end_of_row && (y_cnt == 10'(`SCREEN_HEIGHT - 1));

    // counters rest at zero while idle, so a new frame starts at (0,0)
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy  <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (busy) begin
            if (end_of_frame) begin
                busy  <= 1'b0;
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (end_of_row) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 10'd1;
            end else begin
                x_cnt <= x_cnt + 10'd1;
            end
        end else if (frame_start) begin
            // strobes during a scan fall into the branch above and are dropped
            busy <= 1'b1;
        end
    end

    // one pixel on every busy cycle
    assign pixel_valid = busy;
    assign pixel.x     = x_cnt;
    assign pixel.y     = y_cnt;
    assign pixel.last  = end_of_frame;

endmodule

// File: rtl/inv_sqrt.sv
`timescale 1ns/100ps
`include "ray_consts.svh"

module inv_sqrt (
    input  logic               clk,
    input  logic               rst,
    input  fixed_point_pkg::fp x,
    input  logic               valid_in,
    output fixed_point_pkg::fp inv_sqrt,
    output logic               valid_out
);

    localparam fixed_point_pkg::fp THREE = 3 * `FP_ONE;

    // 1/sqrt(m) at the midpoint of each bucket, unsigned 0.16
    // entries 0-7 cover [1,2) in steps of 1/8, entries 8-15 cover [2,4) in steps of 1/4
    function automatic logic [15:0] seed_lookup(input logic [3:0] idx);
        case (idx)
            4'd0:    return 16'hf85b;
            4'd1:    return 16'heaec;
            4'd2:    return 16'hdf74;
            4'd3:    return 16'hd585;
            4'd4:    return 16'hcccd;
            4'd5:    return 16'hc512;
            4'd6:    return 16'hbe28;
            4'd7:    return 16'hb7ea;
            4'd8:    return 16'haf9d;
            4'd9:    return 16'ha61e;
            4'd10:   return 16'h9e02;
            4'd11:   return 16'h96fb;
            4'd12:   return 16'h90d1;
            4'd13:   return 16'h8b59;
            4'd14:   return 16'h8676;
            default: return 16'h820c;
        endcase
    endfunction

    // y * (3 - m*y^2) / 2
    function automatic fixed_point_pkg::fp newton_step(
        input fixed_point_pkg::fp y,
        input fixed_point_pkg::fp m
    );
        fixed_point_pkg::fp y_sq;
        fixed_point_pkg::fp resid;
        y_sq  = fixed_point_pkg::fp_mul(y, y);
        resid = THREE - fixed_point_pkg::fp_mul(m, y_sq);
        return fixed_point_pkg::fp_mul(y, resid) >>> 1;
    endfunction

    logic [4:0]  lz;
    logic [31:0] norm;
    logic [3:0]  seed_idx;

    fixed_point_pkg::fp m_r1, m_r2, m_r3;
    fixed_point_pkg::fp y_r2, y_r3, y_r4;
    logic [3:0]         half_r1, half_r2, half_r3, half_r4;
    logic               zero_r1, zero_r2, zero_r3, zero_r4;
    logic [`INV_SQRT_LATENCY-1:0] valid_pipe;

    // leading zeros, the highest set bit wins
    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (x[i]) begin
                lz = 5'(31 - i);
            end
        end
        // even shift leaves the top bit at 31 or 30, so m = norm/2^30 is in [1,4)
        norm = x << {lz[4:1], 1'b0};
    end

    // x = m * 4^(3 - half), hence 1/sqrt(x) = 1/sqrt(m) * 2^(half - 3)
    always_ff @(posedge clk) begin
        m_r1    <= fixed_point_pkg::fp'({6'd0, norm[31:6]});
        half_r1 <= lz[4:1];
        zero_r1 <= x[31] || (x == '0);
    end

    // m[25] set means [2,4), else [1,2) with one more fraction bit in the index
    assign seed_idx = m_r1[25] ? {1'b1, m_r1[24:22]} : {1'b0, m_r1[23:21]};

    always_ff @(posedge clk) begin
        y_r2    <= fixed_point_pkg::fp'({8'd0, seed_lookup(seed_idx), 8'd0});
        m_r2    <= m_r1;
        half_r2 <= half_r1;
        zero_r2 <= zero_r1;
    end

    // two refinements take the seed error from a few percent to about 2^-18
    always_ff @(posedge clk) begin
        y_r3    <= newton_step(y_r2, m_r2);
        m_r3    <= m_r2;
        half_r3 <= half_r2;
        zero_r3 <= zero_r2;
        y_r4    <= newton_step(y_r3, m_r3);
        half_r4 <= half_r3;
        zero_r4 <= zero_r3;
    end

    // undo the range normalization
    always_ff @(posedge clk) begin
        if (zero_r4) begin
            inv_sqrt <= '0;
        end else if (half_r4 >= 4'd3) begin
            inv_sqrt <= y_r4 <<< (half_r4 - 4'd3);
        end else begin
            inv_sqrt <= y_r4 >>> (4'd3 - half_r4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`INV_SQRT_LATENCY-2:0], valid_in};
        end
    end

    assign valid_out = valid_pipe[`INV_SQRT_LATENCY-1];

endmodule

// File: rtl/ray_generator.sv
`timescale 1ns/100ps
`include "ray_consts.svh"

module ray_generator (
    input  logic                  clk,
    input  logic                  rst,
    input  ray_pkg::pixel_coord_t pixel,
    input  logic                  pixel_valid,
    input  fixed_point_pkg::fp    tan_half_fov,
    output ray_pkg::ray_t         ray,
    output logic                  ray_valid
);

    // pixel centre doubled, 2x+1, so the half-pixel offset stays an integer
    logic signed [11:0] centre_x2;
    logic signed [11:0] centre_y2;
    logic signed [63:0] scaled_x;
    logic signed [63:0] scaled_y;

    fixed_point_pkg::fp    ndc_x_r1;
    fixed_point_pkg::fp    ndc_y_r1;
    ray_pkg::pixel_coord_t pixel_r1;
    logic                  valid_r1;

    fixed_point_pkg::fp    right_r2;
    fixed_point_pkg::fp    up_r2;
    ray_pkg::pixel_coord_t pixel_r2;
    logic                  valid_r2;

    fixed_point_pkg::vec3  cam_vec;
    ray_pkg::ray_t         cam_ray_r3;
    fixed_point_pkg::fp    mag_sq;
    logic                  mag_sq_valid;

    // unnormalized ray waits here for inv_sqrt
    ray_pkg::ray_t         delay_line [`INV_SQRT_LATENCY];
    fixed_point_pkg::fp    inv_mag;
    logic                  inv_mag_valid;

    always_comb begin
        centre_x2 = signed'({1'b0, pixel.x, 1'b1});
        centre_y2 = signed'({1'b0, pixel.y, 1'b1});
        scaled_x  = 64'(centre_x2) * 64'(`INV_HALF_WIDTH);
        scaled_y  = 64'(centre_y2) * 64'(`INV_HALF_HEIGHT);
    end

    // stage 1: ndc in [-1,1], y flipped so up is positive
    always_ff @(posedge clk) begin
        ndc_x_r1 <= fixed_point_pkg::fp'(scaled_x >>> 1) - `FP_ONE;
        ndc_y_r1 <= `FP_ONE - fixed_point_pkg::fp'(scaled_y >>> 1);
        pixel_r1 <= pixel;
    end

    // stage 2: scale by aspect ratio and field of view
    always_ff @(posedge clk) begin
        right_r2 <= fixed_point_pkg::fp_mul(
            fixed_point_pkg::fp_mul(ndc_x_r1, `ASPECT_RATIO), tan_half_fov);
        up_r2    <= fixed_point_pkg::fp_mul(ndc_y_r1, tan_half_fov);
        pixel_r2 <= pixel_r1;
    end

    // stage 3: camera-space ray looking down -z
    always_comb begin
        cam_vec.x = right_r2;
        cam_vec.y = up_r2;
        cam_vec.z = -`FP_ONE;
    end

    always_ff @(posedge clk) begin
        cam_ray_r3.direction <= cam_vec;
        cam_ray_r3.pixel     <= pixel_r2;
        mag_sq               <= fixed_point_pkg::vec3_dot(cam_vec, cam_vec);
    end

    // mag_sq is at least 1 here, so inv_sqrt never sees zero
    inv_sqrt u_inv_sqrt (
        .clk       (clk),
        .rst       (rst),
        .x         (mag_sq),
        .valid_in  (mag_sq_valid),
        .inv_sqrt  (inv_mag),
        .valid_out (inv_mag_valid)
    );

    always_ff @(posedge clk) begin
        delay_line[0] <= cam_ray_r3;
        for (int i = 1; i < `INV_SQRT_LATENCY; i++) begin
            delay_line[i] <= delay_line[i - 1];
        end
    end

    // stage 5: scale each component to unit length
    always_ff @(posedge clk) begin
        ray.direction.x <= fixed_point_pkg::fp_mul(
            delay_line[`INV_SQRT_LATENCY-1].direction.x, inv_mag);
        ray.direction.y <= fixed_point_pkg::fp_mul(
            delay_line[`INV_SQRT_LATENCY-1].direction.y, inv_mag);
        ray.direction.z <= fixed_point_pkg::fp_mul(
            delay_line[`INV_SQRT_LATENCY-1].direction.z, inv_mag);
        ray.pixel       <= delay_line[`INV_SQRT_LATENCY-1].pixel;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_r1     <= 1'b0;
            valid_r2     <= 1'b0;
            mag_sq_valid <= 1'b0;
            ray_valid    <= 1'b0;
        end else begin
            valid_r1     <= pixel_valid;
            valid_r2     <= valid_r1;
            mag_sq_valid <= valid_r2;
            ray_valid    <= inv_mag_valid;
        end
    end

endmodule

// File: rtl/ray_gen_top.sv
`timescale 1ns/100ps

module ray_gen_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame_start,
    // held stable for the whole frame
    input  fixed_point_pkg::fp tan_half_fov,
    output ray_pkg::ray_t      ray,
    output logic               ray_valid,
    output logic               busy
);

    ray_pkg::pixel_coord_t pixel;
    logic                  pixel_valid;

    pixel_scanner u_pixel_scanner (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .busy        (busy)
    );

    // first ray leaves 9 cycles after the first pixel
    ray_generator u_ray_generator (
        .clk          (clk),
        .rst          (rst),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .tan_half_fov (tan_half_fov),
        .ray          (ray),
        .ray_valid    (ray_valid)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low over the first 4 rising edges
    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// File: verification/ray_gen_tb.sv
`timescale 1ns/100ps
`include "ray_consts.svh"

module ray_gen_tb;

    localparam int  NUM_FRAMES     = 6;
    localparam int  PIXELS         = `SCREEN_WIDTH * `SCREEN_HEIGHT;
    localparam int  FIRST_RAY_LAG  = 10;
    localparam int  TIMEOUT_CYCLES = NUM_FRAMES * (PIXELS + 40) + 100;
    localparam real COMP_TOL       = 1.0 / 4096.0;
    localparam real LEN_TOL        = 1.0 / 1024.0;

    // one expected ray queued when its frame is accepted
    typedef struct packed {
        int          due_cycle;
        logic [9:0]  x;
        logic [9:0]  y;
        logic        last;
        logic [31:0] tan;
    } expected_ray_t;

    logic               clk;
    logic               rst;
    logic               frame_start;
    fixed_point_pkg::fp tan_half_fov;
    ray_pkg::ray_t      ray;
    logic               ray_valid;
    logic               busy;

    int            cycle = 0;
    int            busy_first;
    int            busy_last;
    int            frames_accepted;
    int            rays_checked;
    int            value_errors;
    int            protocol_errors;
    logic [31:0]   lfsr_state;
    expected_ray_t expected_q[$];
    real           frame_dx [`SCREEN_HEIGHT][`SCREEN_WIDTH];
    real           frame_dy [`SCREEN_HEIGHT][`SCREEN_WIDTH];

    tb_clock_gen u_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ray_gen_top u_ray_gen_top (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .tan_half_fov (tan_half_fov),
        .ray          (ray),
        .ray_valid    (ray_valid),
        .busy         (busy)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic real fp_to_real(input logic signed [31:0] v);
        return $itor(v) / 16777216.0;
    endfunction

    function automatic real real_abs(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // pinhole camera looking down -z with the direction normalized
    task automatic model_direction(input int px, input int py, input real tan_fov,
                                   output real dx, output real dy, output real dz);
        real ndc_x;
        real ndc_y;
        real right;
        real up;
        real mag;
        ndc_x = (2.0 * px + 1.0) / `SCREEN_WIDTH - 1.0;
        ndc_y = 1.0 - (2.0 * py + 1.0) / `SCREEN_HEIGHT;
        right = ndc_x * (1.0 * `SCREEN_WIDTH / `SCREEN_HEIGHT) * tan_fov;
        up    = ndc_y * tan_fov;
        mag   = $sqrt(right * right + up * up + 1.0);
        dx    = right / mag;
        dy    = up / mag;
        dz    = -1.0 / mag;
    endtask

    // strobe sampled at edge c+1 keeps the scanner busy after edges c+1 .. c+PIXELS
    task automatic accept_frame(input int c);
        expected_ray_t e;
        busy_first = c + 1;
        busy_last  = c + PIXELS;
        frames_accepted++;
        for (int py = 0; py < `SCREEN_HEIGHT; py++) begin
            for (int px = 0; px < `SCREEN_WIDTH; px++) begin
                e.due_cycle = c + FIRST_RAY_LAG + py * `SCREEN_WIDTH + px;
                e.x         = 10'(px);
                e.y         = 10'(py);
                e.last      = (px == `SCREEN_WIDTH - 1) && (py == `SCREEN_HEIGHT - 1);
                e.tan       = tan_half_fov;
                expected_q.push_back(e);
            end
        end
    endtask

    task automatic send_strobe();
        frame_start = 1'b1;
        if (cycle > busy_last) begin
            accept_frame(cycle);
        end
        tick();
        frame_start = 1'b0;
    endtask

    task automatic check_ray(input expected_ray_t exp_ray);
        real ex;
        real ey;
        real ez;
        real dx;
        real dy;
        real dz;
        real len_sq;
        int  px;
        int  py;
        px = exp_ray.x;
        py = exp_ray.y;
        if (ray.pixel.x !== exp_ray.x || ray.pixel.y !== exp_ray.y ||
            ray.pixel.last !== exp_ray.last) begin
            value_errors++;
            $display("Mismatch at %0t: pixel tag (%0d,%0d,%b), expected (%0d,%0d,%b)", $time,
                     ray.pixel.x, ray.pixel.y, ray.pixel.last, px, py, exp_ray.last);
        end
        model_direction(px, py, fp_to_real(exp_ray.tan), ex, ey, ez);
        dx = fp_to_real(ray.direction.x);
        dy = fp_to_real(ray.direction.y);
        dz = fp_to_real(ray.direction.z);
        if (real_abs(dx - ex) > COMP_TOL || real_abs(dy - ey) > COMP_TOL ||
            real_abs(dz - ez) > COMP_TOL) begin
            value_errors++;
            $display("Mismatch at %0t: pixel (%0d,%0d) direction (%f,%f,%f), model (%f,%f,%f)",
                     $time, px, py, dx, dy, dz, ex, ey, ez);
        end
        len_sq = dx * dx + dy * dy + dz * dz;
        if (real_abs(len_sq - 1.0) > LEN_TOL || dz >= 0.0) begin
            value_errors++;
            $display("Mismatch at %0t: pixel (%0d,%0d) squared length %f, z %f", $time,
                     px, py, len_sq, dz);
        end
        frame_dx[py][px] = dx;
        frame_dy[py][px] = dy;
        // mirror partners earlier in raster order
        if (px >= `SCREEN_WIDTH / 2) begin
            ex = frame_dx[py][`SCREEN_WIDTH - 1 - px];
            if (!(ex < 0.0 && dx > 0.0) || real_abs(dx + ex) > 2.0 * COMP_TOL) begin
                value_errors++;
                $display("Mismatch at %0t: pixel (%0d,%0d) x %f does not mirror %f", $time,
                         px, py, dx, ex);
            end
        end
        if (py >= `SCREEN_HEIGHT / 2) begin
            ey = frame_dy[`SCREEN_HEIGHT - 1 - py][px];
            if (!(ey > 0.0 && dy < 0.0) || real_abs(dy + ey) > 2.0 * COMP_TOL) begin
                value_errors++;
                $display("Mismatch at %0t: pixel (%0d,%0d) y %f does not mirror %f", $time,
                         px, py, dy, ey);
            end
        end
        rays_checked++;
    endtask

    // outputs are sampled on the falling edge away from the drive time
    task automatic check_outputs();
        expected_ray_t exp_ray;
        logic          expect_busy;
        expect_busy = (cycle >= busy_first) && (cycle <= busy_last);
        if (busy !== expect_busy) begin
            protocol_errors++;
            $display("Mismatch at %0t: busy is %b, expected %b", $time, busy, expect_busy);
        end
        if (expected_q.size() != 0 && expected_q[0].due_cycle == cycle) begin
            exp_ray = expected_q.pop_front();
            if (ray_valid !== 1'b1) begin
                protocol_errors++;
                $display("Error at %0t: no ray came out for pixel (%0d,%0d) when it was due",
                         $time, exp_ray.x, exp_ray.y);
            end else begin
                check_ray(exp_ray);
            end
        end else if (ray_valid !== 1'b0) begin
            protocol_errors++;
            $display("Error at %0t: ray_valid is high while no ray is expected", $time);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_outputs();
        end
    end

    initial begin
        logic [31:0] bits;
        frame_start     = 1'b0;
        tan_half_fov    = 32'h0040_0000;
        lfsr_state      = 32'hb799_6f95;
        busy_first      = 1;
        busy_last       = 0;
        frames_accepted = 0;
        rays_checked    = 0;
        value_errors    = 0;
        protocol_errors = 0;
        @(posedge rst);
        // busy and ray_valid must stay low while idle after reset
        repeat (8) tick();
        for (int frame = 0; frame < NUM_FRAMES; frame++) begin
            random_bits(4, bits);
            tan_half_fov = 32'h0040_0000 + (bits << 20);
            send_strobe();
            random_bits(1, bits);
            if (bits[0]) begin
                // this strobe lands well inside the scan and must be dropped
                random_bits(7, bits);
                repeat (bits) tick();
                send_strobe();
            end
            while (expected_q.size() != 0) begin
                tick();
            end
            random_bits(4, bits);
            repeat (bits) tick();
        end
        repeat (20) tick();
        if (rays_checked != NUM_FRAMES * PIXELS) begin
            protocol_errors++;
            $display("Error: %0d rays were checked where %0d were expected",
                     rays_checked, NUM_FRAMES * PIXELS);
        end
        $display("errors: %0d value, %0d protocol; %0d rays checked over %0d frames",
                 value_errors, protocol_errors, rays_checked, frames_accepted);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/fixed_point_pkg.sv
rtl/ray_pkg.sv
rtl/pixel_scanner.sv
rtl/inv_sqrt.sv
rtl/ray_generator.sv
rtl/ray_gen_top.sv
verification/tb_clock_gen.sv
verification/ray_gen_tb.sv

// File: Makefile
TOP = ray_gen_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP) \
		-o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
